// File: src/stm_pkg.sv
/*
 * Shared types and constants of the software trace module: debug flits,
 * the core trace port, trace events, packet codes and the register table
 */
package stm_pkg;

   // One flit on the 16-bit debug network
   typedef struct packed {
      logic        valid;
      logic        last;
      logic [15:0] data;
   } dii_flit_t;

   // Execution trace of the core, one retired instruction per valid cycle
   typedef struct packed {
      logic        valid;
      logic [31:0] pc;
      logic [31:0] insn;
      logic        wben;
      logic [4:0]  wbreg;
      logic [31:0] wbdata;
   } trace_exec_t;

   // A software trace event as buffered between decode and packetizer
   typedef struct packed {
      logic [31:0] timestamp;
      logic [15:0] trace_id;
      logic [31:0] value;
   } trace_event_t;

   // Packet type codes, carried in flit 2 of every packet
   localparam logic [15:0] PKT_TYPE_EVENT     = 16'h8000;
   localparam logic [15:0] PKT_TYPE_OVERFLOW  = 16'h8001;
   localparam logic [15:0] PKT_TYPE_REG_READ  = 16'h0010;
   localparam logic [15:0] PKT_TYPE_REG_WRITE = 16'h0011;
   localparam logic [15:0] PKT_TYPE_REG_RESP  = 16'h0020;
   localparam logic [15:0] PKT_TYPE_REG_ERR   = 16'h0021;

   // Packet lengths in flits, header included
   localparam int EVT_PKT_LEN  = 8;
   localparam int OVF_PKT_LEN  = 4;
   localparam int RESP_PKT_LEN = 4;
   localparam int ERR_PKT_LEN  = 3;

   // Register addresses and their read values
   localparam logic [15:0] REG_MOD_TYPE    = 16'h0000;
   localparam logic [15:0] REG_MOD_VERSION = 16'h0001;
   localparam logic [15:0] REG_VALWIDTH    = 16'h0200;
   localparam logic [15:0] MOD_TYPE_STM    = 16'h0004;
   localparam logic [15:0] MOD_VERSION     = 16'h0000;
   localparam logic [15:0] VALWIDTH        = 16'd32;

   // Marker instruction and the register whose value is traced
   localparam logic [15:0] MARKER_OPCODE = 16'h1500;
   localparam logic [4:0]  TRACE_REG     = 5'd3;

   // Trace packets always go to the host
   localparam logic [15:0] HOST_ADDR = 16'h0000;

   localparam int EVENT_FIFO_DEPTH = 4;
   localparam int REQ_FIFO_DEPTH   = 4;

endpackage

// File: src/stm_trace_decode.sv
/*
 * Trace port decoder: keeps a copy of x3, runs the timestamp counter and
 * turns marker instructions into trace events
 */
`timescale 1ns/1ns

module stm_trace_decode import stm_pkg::*; (
   input  logic         clk,
   input  logic         arst_n,
   input  trace_exec_t  trace_port,
   output trace_event_t evt,
   output logic         evt_valid
);

   logic [31:0] x3_copy;
   logic [31:0] timestamp;
   logic        is_marker;

   // A marker retires with the opcode in the upper halfword and a non-zero id below
   assign is_marker = trace_port.valid &&
                      (trace_port.insn[31:16] == MARKER_OPCODE) &&
                      (trace_port.insn[15:0] != 16'h0000);

   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         x3_copy   <= '0;
         timestamp <= '0;
         evt_valid <= 1'b0;
      end else begin
         // Free running, so it simply counts cycles since reset
         timestamp <= timestamp + 32'd1;
         evt_valid <= is_marker;
         // A writeback in the marker cycle itself lands after the sample
         if (trace_port.wben && (trace_port.wbreg == TRACE_REG)) begin
            x3_copy <= trace_port.wbdata;
         end
      end
   end

   // Event fields are sampled in the marker cycle and shown one cycle later
   always_ff @(posedge clk) begin
      if (is_marker) begin
         evt.timestamp <= timestamp;
         evt.trace_id  <= trace_port.insn[15:0];
         evt.value     <= x3_copy;
      end
   end

   // Events in back-to-back cycles come from markers in back-to-back cycles,
   // so their timestamps are exactly one apart
   a_evt_from_marker: assert property (
      @(posedge clk) disable iff (!arst_n)
      evt_valid && $past(evt_valid) |-> (evt.timestamp == $past(evt.timestamp) + 32'd1)
   );

endmodule

// File: src/stm_fifo.sv
/*
 * Synchronous FIFO over any payload type, circular buffer with pointers
 * and an occupancy count
 */
`timescale 1ns/1ns

module stm_fifo #(
   parameter type item_t = logic [15:0],
   parameter int  DEPTH  = 4
) (
   input  logic  clk,
   input  logic  arst_n,
   input  item_t in_data,
   input  logic  in_valid,
   output logic  in_ready,
   output item_t out_data,
   output logic  out_valid,
   input  logic  out_ready
);

   localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
   localparam int CNT_W = $clog2(DEPTH + 1);

   item_t            mem [DEPTH];
   logic [PTR_W-1:0] wr_ptr;
   logic [PTR_W-1:0] rd_ptr;
   logic [CNT_W-1:0] count;
   logic             push;
   logic             pop;

   // Full refuses a push even when a pop happens in the same cycle
   assign in_ready  = (count != CNT_W'(DEPTH));
   assign out_valid = (count != '0);
   assign out_data  = mem[rd_ptr];
   assign push      = in_valid && in_ready;
   assign pop       = out_valid && out_ready;

   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         wr_ptr <= '0;
         rd_ptr <= '0;
         count  <= '0;
      end else begin
         if (push) begin
            wr_ptr <= (wr_ptr == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
         end
         if (pop) begin
            rd_ptr <= (rd_ptr == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
         end
         case ({push, pop})
            2'b10:   count <= count + 1'b1;
            2'b01:   count <= count - 1'b1;
            default: count <= count;
         endcase
      end
   end

   always_ff @(posedge clk) begin
      if (push) begin
         mem[wr_ptr] <= in_data;
      end
   end

   // The occupancy never passes the depth
   a_no_overflow: assert property (
      @(posedge clk) disable iff (!arst_n)
      count <= CNT_W'(DEPTH)
   );

   // The write pointer always sits the occupancy ahead of the read pointer
   a_count_matches_ptrs: assert property (
      @(posedge clk) disable iff (!arst_n)
      ((int'(rd_ptr) + int'(count)) % DEPTH) == int'(wr_ptr)
   );

endmodule

// File: src/stm_packetizer.sv
/*
 * Packetizer: serialises trace events and overflow reports into flits and
 * keeps the saturating count of dropped events
 */
`timescale 1ns/1ns

module stm_packetizer import stm_pkg::*; (
   input  logic         clk,
   input  logic         arst_n,
   input  logic [15:0]  id,
   input  trace_event_t evt,
   input  logic         evt_in_valid,
   output logic         evt_in_ready,
   input  logic         dropped,
   output dii_flit_t    flit_out,
   input  logic         flit_ready
);

   localparam int AHEAD_W = $clog2(EVENT_FIFO_DEPTH + 1);

   logic               busy;
   logic               is_ovf;
   logic [2:0]         idx;
   trace_event_t       evt_q;
   logic [15:0]        ovf_q;
   logic [15:0]        drop_cnt;
   logic [AHEAD_W-1:0] ahead;
   logic               ovf_due;
   logic               ovf_start;
   logic               evt_pop;
   logic               batch_open;
   logic               pkt_last;
   logic [15:0]        flit_data;

   // Events still buffered when the first drop hit must go out before the report
   assign ovf_due      = (drop_cnt != '0) && (ahead == '0);
   assign ovf_start    = !busy && ovf_due;
   assign evt_in_ready = !busy && !ovf_due;
   assign evt_pop      = evt_in_valid && evt_in_ready;
   assign batch_open   = (drop_cnt != '0) && !ovf_start;

   assign pkt_last = is_ovf ? (idx == 3'(OVF_PKT_LEN - 1)) : (idx == 3'(EVT_PKT_LEN - 1));

   always_comb begin
      case (idx)
         3'd0:    flit_data = HOST_ADDR;
         3'd1:    flit_data = id;
         3'd2:    flit_data = is_ovf ? PKT_TYPE_OVERFLOW : PKT_TYPE_EVENT;
         3'd3:    flit_data = is_ovf ? ovf_q : evt_q.timestamp[15:0];
         3'd4:    flit_data = evt_q.timestamp[31:16];
         3'd5:    flit_data = evt_q.trace_id;
         3'd6:    flit_data = evt_q.value[15:0];
         default: flit_data = evt_q.value[31:16];
      endcase
   end

   assign flit_out.valid = busy;
   assign flit_out.last  = pkt_last;
   assign flit_out.data  = flit_data;

   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         busy     <= 1'b0;
         is_ovf   <= 1'b0;
         idx      <= '0;
         drop_cnt <= '0;
         ahead    <= '0;
      end else begin
         // Packets start only at a boundary, with the overflow report first
         if (ovf_start || evt_pop) begin
            busy   <= 1'b1;
            is_ovf <= ovf_start;
            idx    <= '0;
         end else if (busy && flit_ready) begin
            if (pkt_last) begin
               busy <= 1'b0;
            end else begin
               idx <= idx + 3'd1;
            end
         end

         // Drops seen while a report starts belong to the next report
         if (ovf_start) begin
            drop_cnt <= {15'd0, dropped};
         end else if (dropped && (drop_cnt != 16'hffff)) begin
            drop_cnt <= drop_cnt + 16'd1;
         end

         // A drop only happens with the FIFO full, so its depth is what lies ahead
         if (dropped && !batch_open) begin
            ahead <= AHEAD_W'(EVENT_FIFO_DEPTH) - AHEAD_W'(evt_pop);
         end else if (evt_pop && (ahead != '0)) begin
            ahead <= ahead - 1'b1;
         end
      end
   end

   always_ff @(posedge clk) begin
      if (evt_pop) begin
         evt_q <= evt;
      end
      if (ovf_start) begin
         ovf_q <= drop_cnt;
      end
   end

   // A stalled flit holds still until the mux takes it
   a_flit_stable: assert property (
      @(posedge clk) disable iff (!arst_n)
      flit_out.valid && !flit_ready |=> $stable(flit_out)
   );

endmodule

// File: src/stm_reg_access.sv
/*
 * Register access: parses debug request packets and answers reads of the
 * identification registers, everything else with an error
 */
`timescale 1ns/1ns

module stm_reg_access import stm_pkg::*; (
   input  logic        clk,
   input  logic        arst_n,
   input  logic [15:0] id,
   input  dii_flit_t   req,
   output logic        req_ready,
   output dii_flit_t   resp,
   input  logic        resp_ready
);

   logic [2:0]  req_idx;
   logic        dest_ok_q;
   logic [15:0] src_q;
   logic [15:0] type_q;
   logic        resp_busy;
   logic        resp_err;
   logic [1:0]  resp_idx;
   logic [15:0] resp_data_q;
   logic        req_xfer;
   logic        dest_match;
   logic        resp_last;
   logic        reg_hit;
   logic [15:0] reg_value;

   // Requests wait in the FIFO while a response is out
   assign req_ready  = !resp_busy;
   assign req_xfer   = req.valid && req_ready;
   assign dest_match = (req_idx == 3'd0) ? (req.data == id) : dest_ok_q;

   // Register table, looked up with the address flit as it arrives
   always_comb begin
      reg_hit = 1'b1;
      case (req.data)
         REG_MOD_TYPE:    reg_value = MOD_TYPE_STM;
         REG_MOD_VERSION: reg_value = MOD_VERSION;
         REG_VALWIDTH:    reg_value = VALWIDTH;
         default: begin
            reg_hit   = 1'b0;
            reg_value = '0;
         end
      endcase
   end

   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         req_idx   <= '0;
         resp_busy <= 1'b0;
         resp_idx  <= '0;
      end else if (req_xfer) begin
         // Requests for another module are swallowed without a reply
         if (req.last) begin
            req_idx   <= '0;
            resp_busy <= dest_match;
            resp_idx  <= '0;
         end else if (req_idx != 3'd7) begin
            req_idx <= req_idx + 3'd1;
         end
      end else if (resp_busy && resp_ready) begin
         if (resp_last) begin
            resp_busy <= 1'b0;
         end else begin
            resp_idx <= resp_idx + 2'd1;
         end
      end
   end

   always_ff @(posedge clk) begin
      if (req_xfer) begin
         if (req_idx == 3'd0) begin
            dest_ok_q <= (req.data == id);
         end
         if (req_idx == 3'd1) begin
            src_q <= req.data;
         end
         if (req_idx == 3'd2) begin
            type_q <= req.data;
         end
         // Only a complete four-flit read of a known address succeeds
         if (req.last) begin
            resp_err    <= !((req_idx == 3'd3) && (type_q == PKT_TYPE_REG_READ) && reg_hit);
            resp_data_q <= reg_value;
         end
      end
   end

   assign resp_last = resp_err ? (resp_idx == 2'(ERR_PKT_LEN - 1))
                               : (resp_idx == 2'(RESP_PKT_LEN - 1));

   assign resp.valid = resp_busy;
   assign resp.last  = resp_last;
   always_comb begin
      case (resp_idx)
         2'd0:    resp.data = src_q;
         2'd1:    resp.data = id;
         2'd2:    resp.data = resp_err ? PKT_TYPE_REG_ERR : PKT_TYPE_REG_RESP;
         default: resp.data = resp_data_q;
      endcase
   end

endmodule

// File: src/stm_flit_mux.sv
/*
 * Packet level flit multiplexer, input a wins at packet start and the
 * choice is held until the last flit leaves
 */
`timescale 1ns/1ns

module stm_flit_mux import stm_pkg::*; (
   input  logic      clk,
   input  logic      arst_n,
   input  dii_flit_t in_a,
   output logic      ready_a,
   input  dii_flit_t in_b,
   output logic      ready_b,
   output dii_flit_t out_flit,
   input  logic      out_ready
);

   // Selection is 0 for input a and 1 for input b
   logic locked;
   logic sel_q;
   logic sel;

   assign sel      = locked ? sel_q : !in_a.valid;
   assign out_flit = sel ? in_b : in_a;
   assign ready_a  = out_ready && !sel;
   assign ready_b  = out_ready && sel;

   // Lock as soon as a flit is shown, so a stalled first flit cannot be swapped out
   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         locked <= 1'b0;
         sel_q  <= 1'b0;
      end else begin
         locked <= out_flit.valid && !(out_ready && out_flit.last);
         sel_q  <= sel;
      end
   end

   // A packet that has sent a non-last flit keeps the other input waiting
   a_no_switch_from_a: assert property (
      @(posedge clk) disable iff (!arst_n)
      ready_a && in_a.valid && !in_a.last |=> !ready_b
   );

   a_no_switch_from_b: assert property (
      @(posedge clk) disable iff (!arst_n)
      ready_b && in_b.valid && !in_b.last |=> !ready_a
   );

endmodule

// File: src/stm_top.sv
/*
 * Software trace module top level: decode, event and request FIFOs,
 * packetizer, register access and the output mux
 */
`timescale 1ns/1ns

module stm_top import stm_pkg::*; (
   input  logic        clk,
   input  logic        arst_n,
   input  logic [15:0] id,
   input  dii_flit_t   debug_in,
   output logic        debug_in_ready,
   output dii_flit_t   debug_out,
   input  logic        debug_out_ready,
   input  trace_exec_t trace_port
);

   trace_event_t evt;
   logic         evt_valid;
   logic         evt_fifo_in_ready;
   trace_event_t evt_fifo_data;
   logic         evt_fifo_valid;
   logic         evt_fifo_ready;
   logic         dropped;
   dii_flit_t    req_data;
   logic         req_valid;
   logic         req_ready;
   dii_flit_t    req_flit;
   dii_flit_t    trace_flit;
   logic         trace_ready;
   dii_flit_t    resp_flit;
   logic         resp_ready;

   stm_trace_decode i_decode (
      .clk        (clk),
      .arst_n     (arst_n),
      .trace_port (trace_port),
      .evt        (evt),
      .evt_valid  (evt_valid)
   );

   // An event offered to a full FIFO is lost and only counted
   assign dropped = evt_valid && !evt_fifo_in_ready;

   stm_fifo #(
      .item_t (trace_event_t),
      .DEPTH  (EVENT_FIFO_DEPTH)
   ) i_evt_fifo (
      .clk       (clk),
      .arst_n    (arst_n),
      .in_data   (evt),
      .in_valid  (evt_valid),
      .in_ready  (evt_fifo_in_ready),
      .out_data  (evt_fifo_data),
      .out_valid (evt_fifo_valid),
      .out_ready (evt_fifo_ready)
   );

   stm_packetizer i_packetizer (
      .clk          (clk),
      .arst_n       (arst_n),
      .id           (id),
      .evt          (evt_fifo_data),
      .evt_in_valid (evt_fifo_valid),
      .evt_in_ready (evt_fifo_ready),
      .dropped      (dropped),
      .flit_out     (trace_flit),
      .flit_ready   (trace_ready)
   );

   stm_fifo #(
      .item_t (dii_flit_t),
      .DEPTH  (REQ_FIFO_DEPTH)
   ) i_req_fifo (
      .clk       (clk),
      .arst_n    (arst_n),
      .in_data   (debug_in),
      .in_valid  (debug_in.valid),
      .in_ready  (debug_in_ready),
      .out_data  (req_data),
      .out_valid (req_valid),
      .out_ready (req_ready)
   );

   // The stored valid bit is replaced by the FIFO's own occupancy
   assign req_flit = '{valid: req_valid, last: req_data.last, data: req_data.data};

   stm_reg_access i_reg_access (
      .clk        (clk),
      .arst_n     (arst_n),
      .id         (id),
      .req        (req_flit),
      .req_ready  (req_ready),
      .resp       (resp_flit),
      .resp_ready (resp_ready)
   );

   // Register responses sit on the priority input
   stm_flit_mux i_mux (
      .clk       (clk),
      .arst_n    (arst_n),
      .in_a      (resp_flit),
      .ready_a   (resp_ready),
      .in_b      (trace_flit),
      .ready_b   (trace_ready),
      .out_flit  (debug_out),
      .out_ready (debug_out_ready)
   );

endmodule

// File: verification/stm_tb.sv
/*
 * Directed testbench for the software trace module: clock, reset, LFSR stalls,
 * value check, flit collector, trace and register tests, and a timeout
 */
`timescale 1ns/1ns

module stm_tb import stm_pkg::*; ();

   localparam logic [15:0] TB_ID    = 16'h0005;
   localparam logic [15:0] REQ_SRC  = 16'h0001;
   localparam int          N_BURST  = 9;
   // Cycle budget of each test, summed into the run limit
   localparam int T_RESET    = 10;
   localparam int T_IDLE     = 60;
   localparam int T_EVENT    = 200;
   localparam int T_OVERFLOW = 250;
   localparam int T_REG      = 250;
   localparam int T_MIXED    = 400;
   localparam int TIMEOUT_CYCLES = T_RESET + T_IDLE + T_EVENT + T_OVERFLOW + T_REG + T_MIXED;

   logic        clk;
   logic        arst_n;
   dii_flit_t   debug_in;
   logic        debug_in_ready;
   dii_flit_t   debug_out;
   logic        debug_out_ready;
   trace_exec_t trace_port;

   logic [16:0] flit_q [$];
   logic [15:0] pkt [0:15];
   int          pkt_len;
   int          pkt_count;
   int          pkts_taken;
   int          tb_cycle;
   int          run_cycles;
   logic [31:0] lfsr;
   logic        stall_mode;
   logic [31:0] pc_next;

   stm_top i_dut (
      .clk             (clk),
      .arst_n          (arst_n),
      .id              (TB_ID),
      .debug_in        (debug_in),
      .debug_in_ready  (debug_in_ready),
      .debug_out       (debug_out),
      .debug_out_ready (debug_out_ready),
      .trace_port      (trace_port)
   );

   initial begin
      clk = 1'b0;
      forever #5 clk = ~clk;
   end

   // Flits are taken at the falling edge, where inputs and outputs are settled
   always @(negedge clk) begin
      if (arst_n && debug_out.valid && debug_out_ready) begin
         flit_q.push_back({debug_out.last, debug_out.data});
         if (debug_out.last) begin
            pkt_count++;
         end
      end
   end

   initial begin
      run_cycles = 0;
      forever begin
         @(posedge clk);
         run_cycles++;
         if (run_cycles >= TIMEOUT_CYCLES) begin
            $display("Timeout: no result after %0d cycles", run_cycles);
            $display("TEST RESULT: FAIL");
            $fatal(1);
         end
      end
   end

   // Fibonacci LFSR with taps 32, 22, 2 and 1
   function automatic logic [31:0] lfsr_next(input logic [31:0] s);
      return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
   endfunction

   task automatic fail_run(input string msg);
      $display("%s", msg);
      $display("TEST RESULT: FAIL");
      $fatal(1);
   endtask

   task automatic check_value(input string name, input logic [31:0] got,
                              input logic [31:0] exp);
      if (got !== exp) begin
         $display("** Error: %s is %h, expected %h", name, got, exp);
         $display("TEST RESULT: FAIL");
         $fatal(1);
      end
   endtask

   // One clock, with inputs changed just after the rising edge
   task automatic step();
      @(posedge clk);
      #1;
      tb_cycle++;
      if (stall_mode) begin
         lfsr = lfsr_next(lfsr);
         debug_out_ready = lfsr[0];
      end
   endtask

   task automatic set_ready(input logic value);
      stall_mode      = 1'b0;
      debug_out_ready = value;
   endtask

   task automatic retire(input logic [31:0] insn, input logic wben,
                         input logic [4:0] wbreg, input logic [31:0] wbdata);
      trace_port.valid  = 1'b1;
      trace_port.pc     = pc_next;
      trace_port.insn   = insn;
      trace_port.wben   = wben;
      trace_port.wbreg  = wbreg;
      trace_port.wbdata = wbdata;
      pc_next = pc_next + 32'd4;
      step();
      trace_port = '0;
   endtask

   // The cycle of the marker is kept so that timestamp steps can be predicted
   task automatic send_marker(input logic [15:0] trace_id, output int cycle);
      cycle = tb_cycle;
      retire({MARKER_OPCODE, trace_id}, 1'b0, 5'd0, 32'd0);
   endtask

   task automatic send_flit(input logic last, input logic [15:0] data);
      debug_in.valid = 1'b1;
      debug_in.last  = last;
      debug_in.data  = data;
      while (!debug_in_ready) begin
         step();
      end
      step();
      debug_in = '0;
   endtask

   task automatic send_request(input logic [15:0] dest, input logic [15:0] typ,
                               input logic [15:0] addr, input logic with_data);
      send_flit(1'b0, dest);
      send_flit(1'b0, REQ_SRC);
      send_flit(1'b0, typ);
      send_flit(!with_data, addr);
      if (with_data) begin
         send_flit(1'b1, 16'hbeef);
      end
   endtask

   // Waits for a whole packet and moves it out of the collected flits
   task automatic pop_packet();
      logic [16:0] f;
      pkt_len = 0;
      while (pkt_count == pkts_taken) begin
         step();
      end
      pkts_taken++;
      do begin
         f = flit_q.pop_front();
         if (pkt_len < 16) begin
            pkt[pkt_len] = f[15:0];
         end
         pkt_len++;
      end while (!f[16]);
   endtask

   task automatic expect_quiet(input int cycles, input string what);
      repeat (cycles) step();
      if (flit_q.size() != 0) begin
         fail_run({"Output flits appeared after ", what});
      end
   endtask

   task automatic check_event(input logic [15:0] trace_id, input logic [31:0] value,
                              output logic [31:0] ts);
      check_value("event packet length", pkt_len, 8);
      check_value("event destination", pkt[0], HOST_ADDR);
      check_value("event source", pkt[1], TB_ID);
      check_value("event type", pkt[2], PKT_TYPE_EVENT);
      check_value("event trace_id", pkt[5], trace_id);
      check_value("event value", {pkt[7], pkt[6]}, value);
      ts = {pkt[4], pkt[3]};
   endtask

   task automatic check_response(input logic [15:0] data);
      check_value("response length", pkt_len, 4);
      check_value("response destination", pkt[0], REQ_SRC);
      check_value("response source", pkt[1], TB_ID);
      check_value("response type", pkt[2], PKT_TYPE_REG_RESP);
      check_value("response data", pkt[3], data);
   endtask

   task automatic check_error();
      check_value("error length", pkt_len, 3);
      check_value("error destination", pkt[0], REQ_SRC);
      check_value("error source", pkt[1], TB_ID);
      check_value("error type", pkt[2], PKT_TYPE_REG_ERR);
   endtask

   task automatic test_idle();
      step();
      check_value("debug_out.valid", debug_out.valid, 1'b0);
      check_value("debug_in_ready", debug_in_ready, 1'b1);
      repeat (8) retire(32'h0000_0013, 1'b0, 5'd0, 32'd0);
      retire(32'h1501_0007, 1'b0, 5'd0, 32'd0);
      expect_quiet(20, "instructions without markers");
   endtask

   task automatic test_event();
      logic [31:0] ts_a;
      logic [31:0] ts_b;
      int          cyc_a;
      int          cyc_b;
      retire(32'h0010_0193, 1'b1, TRACE_REG, 32'hdead_beef);
      send_marker(16'h0042, cyc_a);
      pop_packet();
      check_event(16'h0042, 32'hdead_beef, ts_a);
      // A zero id and other writebacks leave no trace
      retire({MARKER_OPCODE, 16'h0000}, 1'b0, 5'd0, 32'd0);
      retire(32'h0010_0293, 1'b1, 5'd5, 32'h5555_aaaa);
      expect_quiet(20, "a marker with id 0");
      send_marker(16'h0043, cyc_b);
      pop_packet();
      check_event(16'h0043, 32'hdead_beef, ts_b);
      check_value("timestamp step", ts_b - ts_a, cyc_b - cyc_a);
   endtask

   task automatic test_overflow();
      logic [31:0] ts;
      logic [31:0] prev_ts;
      int          mcyc [0:N_BURST];
      int          i;
      set_ready(1'b0);
      retire(32'h0020_0193, 1'b1, TRACE_REG, 32'h1234_5678);
      for (i = 0; i < N_BURST; i++) begin
         send_marker(16'h0101 + 16'(i), mcyc[i]);
      end
      repeat (5) step();
      set_ready(1'b1);
      // One event sits in the packetizer and the FIFO holds the rest
      for (i = 0; i < EVENT_FIFO_DEPTH + 1; i++) begin
         pop_packet();
         check_event(16'h0101 + 16'(i), 32'h1234_5678, ts);
         if (i > 0) begin
            check_value("burst timestamp step", ts - prev_ts, mcyc[i] - mcyc[i - 1]);
         end
         prev_ts = ts;
      end
      pop_packet();
      check_value("overflow length", pkt_len, 4);
      check_value("overflow destination", pkt[0], HOST_ADDR);
      check_value("overflow source", pkt[1], TB_ID);
      check_value("overflow type", pkt[2], PKT_TYPE_OVERFLOW);
      check_value("overflow count", pkt[3], N_BURST - (EVENT_FIFO_DEPTH + 1));
      send_marker(16'h0110, mcyc[N_BURST]);
      pop_packet();
      check_event(16'h0110, 32'h1234_5678, ts);
      expect_quiet(10, "the overflow test");
   endtask

   task automatic test_registers();
      send_request(TB_ID, PKT_TYPE_REG_READ, REG_MOD_TYPE, 1'b0);
      pop_packet();
      check_response(16'h0004);
      send_request(TB_ID, PKT_TYPE_REG_READ, REG_MOD_VERSION, 1'b0);
      pop_packet();
      check_response(16'h0000);
      send_request(TB_ID, PKT_TYPE_REG_READ, REG_VALWIDTH, 1'b0);
      pop_packet();
      check_response(16'd32);
      send_request(TB_ID, PKT_TYPE_REG_READ, 16'h0100, 1'b0);
      pop_packet();
      check_error();
      send_request(TB_ID, PKT_TYPE_REG_WRITE, REG_MOD_TYPE, 1'b1);
      pop_packet();
      check_error();
      send_request(16'h0009, PKT_TYPE_REG_READ, REG_MOD_TYPE, 1'b0);
      expect_quiet(20, "a request for another module");
   endtask

   task automatic test_mixed();
      logic [31:0] ts;
      int          cyc;
      int          n_evt;
      int          n_resp;
      int          i;
      stall_mode = 1'b1;
      retire(32'h0030_0193, 1'b1, TRACE_REG, 32'h0bad_cafe);
      send_marker(16'h0201, cyc);
      send_marker(16'h0202, cyc);
      send_request(TB_ID, PKT_TYPE_REG_READ, REG_VALWIDTH, 1'b0);
      send_marker(16'h0203, cyc);
      step();
      send_marker(16'h0204, cyc);
      n_evt  = 0;
      n_resp = 0;
      // Responses and events may come in any order, events stay in order
      for (i = 0; i < 5; i++) begin
         pop_packet();
         if (pkt_len < 3) begin
            fail_run("A packet shorter than its header arrived");
         end else if ((pkt[2] == PKT_TYPE_EVENT) && (n_evt < 4)) begin
            check_event(16'h0201 + 16'(n_evt), 32'h0bad_cafe, ts);
            n_evt++;
         end else if ((pkt[2] == PKT_TYPE_REG_RESP) && (n_resp == 0)) begin
            check_response(16'd32);
            n_resp++;
         end else begin
            fail_run("An unexpected or broken packet arrived under random stalls");
         end
      end
      set_ready(1'b1);
      expect_quiet(30, "the mixed traffic test");
   endtask

   initial begin
      arst_n          = 1'b0;
      debug_in        = '0;
      debug_out_ready = 1'b1;
      trace_port      = '0;
      stall_mode      = 1'b0;
      lfsr            = 32'ha88b_258f;
      pc_next         = 32'h0000_1000;
      pkt_count       = 0;
      pkts_taken      = 0;
      pkt_len         = 0;
      tb_cycle        = 0;
      repeat (4) @(posedge clk);
      #1;
      arst_n = 1'b1;
      test_idle();
      test_event();
      test_overflow();
      test_registers();
      test_mixed();
      $display("TEST RESULT: PASS");
      $finish;
   end

endmodule

// File: src.f
src/stm_pkg.sv
src/stm_trace_decode.sv
src/stm_fifo.sv
src/stm_packetizer.sv
src/stm_reg_access.sv
src/stm_flit_mux.sv
src/stm_top.sv
verification/stm_tb.sv
